/* Bender.yml */
package:
  name: mem_unit

sources:
  - rtl/lsu_pkg.sv
  - rtl/agu.sv
  - rtl/lsq.sv
  - rtl/load_writeback.sv
  - rtl/mem_unit_top.sv
  - target: test
    files:
      - verification/tb_mem_unit.sv

/* all.f */
rtl/lsu_pkg.sv
rtl/agu.sv
rtl/lsq.sv
rtl/load_writeback.sv
rtl/mem_unit_top.sv
verification/tb_mem_unit.sv

/* rtl/agu.sv */
`default_nettype none

module agu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  agu_valid,
    input  lsu_pkg::agu_req_t     agu_req,
    input  logic                  flush,
    output logic                  addr_valid,
    output lsu_pkg::agu_result_t  addr_res
);

    logic [31:0] sum;

    assign sum = agu_req.base + agu_req.offset;

    // result for a squashed entry must not reach the queue
    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            addr_valid <= 1'b0;
        end else begin
            addr_valid <= agu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (agu_valid) begin
            addr_res.lsq_idx    <= agu_req.lsq_idx;
            addr_res.addr       <= sum;
            addr_res.store_data <= agu_req.store_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/load_writeback.sv */
`default_nettype none

module load_writeback (
    input  logic              clk,
    input  logic              rst,
    input  lsu_pkg::retire_t  ret,
    output lsu_pkg::cdb_t     cdb
);

    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic [31:0] ext;
    logic        is_load;

    assign is_load = (ret.inst.op == lsu_pkg::op_load);
    assign lane_b  = ret.rdata[{ret.offset, 3'b000} +: 8];
    assign lane_h  = ret.rdata[{ret.offset[1], 4'b0000} +: 16];

    always_comb begin
        case (ret.inst.funct3)
            lsu_pkg::F3_B:  ext = {{24{lane_b[7]}}, lane_b};
            lsu_pkg::F3_BU: ext = {24'b0, lane_b};
            lsu_pkg::F3_H:  ext = {{16{lane_h[15]}}, lane_h};
            lsu_pkg::F3_HU: ext = {16'b0, lane_h};
            default:        ext = ret.rdata;    // lw
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= ret.valid;
        end

        if (ret.valid) begin
            cdb.rob_idx <= ret.inst.rob_idx;
            if (is_load) begin
                cdb.pd    <= ret.inst.pd;
                cdb.rd    <= ret.inst.rd;
                cdb.value <= ext;
            end else begin
                // stores only mark the rob entry done
                cdb.pd    <= '0;
                cdb.rd    <= '0;
                cdb.value <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/lsq.sv */
`default_nettype none

module lsq #(
    parameter int QUEUE_DEPTH = lsu_pkg::LSQ_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic                            enq_valid,
    input  lsu_pkg::dispatch_t              enq,
    input  logic                            addr_valid,
    input  lsu_pkg::agu_result_t            addr_res,
    input  logic [lsu_pkg::ROB_IDX_W-1:0]   commit_rob,
    input  logic                            dc_resp_valid,
    input  logic [31:0]                     dc_rdata,
    output logic                            full,
    output logic [lsu_pkg::LSQ_IDX_W-1:0]   next_idx,
    output lsu_pkg::dcache_req_t            dc_req,
    output lsu_pkg::retire_t                ret
);

    localparam int IDX_W = $clog2(QUEUE_DEPTH);

    if (QUEUE_DEPTH > (1 << lsu_pkg::LSQ_IDX_W)) begin : g_depth_check
        $error("lsq: QUEUE_DEPTH does not fit the queue index width");
    end

    lsu_pkg::lsq_entry_t entries [QUEUE_DEPTH];
    lsu_pkg::lsq_entry_t head_e;

    logic [IDX_W:0]   head;     // msb is the wrap bit
    logic [IDX_W:0]   tail;
    logic [IDX_W-1:0] upd_idx;
    logic [1:0]       off;
    logic [3:0]       mask;
    logic [31:0]      lane;
    logic             issue;
    logic             do_retire;
    logic             do_enq;

    assign head_e  = entries[head[IDX_W-1:0]];
    assign upd_idx = addr_res.lsq_idx[IDX_W-1:0];
    assign off     = head_e.addr[1:0];

    assign full = (head[IDX_W-1:0] == tail[IDX_W-1:0]) && (head[IDX_W] != tail[IDX_W]);

    // head may only go out once the rob says it is the oldest
    assign issue     = head_e.valid && head_e.addr_ready && (head_e.inst.rob_idx == commit_rob);
    assign do_retire = issue && dc_resp_valid;
    assign do_enq    = enq_valid && (!full || do_retire);   // slot freed this cycle

    always_comb begin
        next_idx = '0;
        next_idx[IDX_W-1:0] = tail[IDX_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (do_retire) begin
                head <= head + 1'b1;
            end
            if (do_enq) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // later writes win, so an enqueue into the slot just retired keeps it valid
    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                entries[i].valid      <= 1'b0;
                entries[i].addr_ready <= 1'b0;
            end
        end else begin
            if (addr_valid) begin
                entries[upd_idx].addr_ready <= 1'b1;
                entries[upd_idx].addr       <= addr_res.addr;
                entries[upd_idx].store_data <= addr_res.store_data;
            end
            if (do_retire) begin
                entries[head[IDX_W-1:0]].valid      <= 1'b0;
                entries[head[IDX_W-1:0]].addr_ready <= 1'b0;
            end
            if (do_enq) begin
                entries[tail[IDX_W-1:0]].valid      <= 1'b1;
                entries[tail[IDX_W-1:0]].addr_ready <= 1'b0;
                entries[tail[IDX_W-1:0]].inst       <= enq;
            end
        end
    end

    // byte enables and lane placement for the head entry
    always_comb begin
        case (head_e.inst.funct3)
            lsu_pkg::F3_B, lsu_pkg::F3_BU: begin
                mask = 4'b0001 << off;
                lane = {24'b0, head_e.store_data[7:0]} << {off, 3'b000};
            end
            lsu_pkg::F3_H, lsu_pkg::F3_HU: begin
                mask = 4'b0011 << off;
                lane = {16'b0, head_e.store_data[15:0]} << {off, 3'b000};
            end
            default: begin
                mask = 4'b1111;    // word
                lane = head_e.store_data;
            end
        endcase
    end

    always_comb begin
        dc_req = '0;
        if (issue) begin
            dc_req.addr = {head_e.addr[31:2], 2'b00};
            if (head_e.inst.op == lsu_pkg::op_load) begin
                dc_req.rmask = mask;
            end else begin
                dc_req.wmask = mask;
                dc_req.wdata = lane;
            end
        end
    end

    always_comb begin
        ret.valid  = do_retire;
        ret.inst   = head_e.inst;
        ret.offset = off;
        ret.rdata  = dc_rdata;
    end

    // dispatch stalls on full unless the head leaves in the same cycle
    a_no_enq_full: assert property (@(posedge clk) disable iff (!rst || flush)
        (enq_valid && full) |-> do_retire);

    a_resp_has_req: assert property (@(posedge clk) disable iff (!rst)
        dc_resp_valid |-> ((dc_req.rmask != '0) || (dc_req.wmask != '0)));

    // agu only ever sees indices handed out by dispatch
    a_addr_target: assert property (@(posedge clk) disable iff (!rst || flush)
        addr_valid |-> entries[upd_idx].valid);

endmodule

`default_nettype wire

/* rtl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int LSQ_DEPTH  = 8;
    localparam int LSQ_IDX_W  = 3;
    localparam int ROB_IDX_W  = 5;
    localparam int PHYS_REG_W = 6;
    localparam int ARCH_REG_W = 5;

    // rv32i load/store funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_t;

    typedef struct packed {
        mem_op_t                 op;
        logic [2:0]              funct3;
        logic [ROB_IDX_W-1:0]    rob_idx;
        logic [PHYS_REG_W-1:0]   pd;
        logic [ARCH_REG_W-1:0]   rd;
    } dispatch_t;

    typedef struct packed {
        logic [LSQ_IDX_W-1:0]    lsq_idx;
        logic [31:0]             base;
        logic [31:0]             offset;     // sign-extended immediate
        logic [31:0]             store_data;
    } agu_req_t;

    typedef struct packed {
        logic [LSQ_IDX_W-1:0]    lsq_idx;
        logic [31:0]             addr;
        logic [31:0]             store_data;
    } agu_result_t;

    typedef struct packed {
        logic                    valid;
        logic                    addr_ready;
        dispatch_t               inst;
        logic [31:0]             addr;
        logic [31:0]             store_data;
    } lsq_entry_t;

    typedef struct packed {
        logic [31:0]             addr;       // word aligned
        logic [3:0]              rmask;
        logic [3:0]              wmask;
        logic [31:0]             wdata;
    } dcache_req_t;

    typedef struct packed {
        logic                    valid;
        dispatch_t               inst;
        logic [1:0]              offset;     // byte within word
        logic [31:0]             rdata;
    } retire_t;

    typedef struct packed {
        logic                    valid;
        logic [ROB_IDX_W-1:0]    rob_idx;
        logic [PHYS_REG_W-1:0]   pd;
        logic [ARCH_REG_W-1:0]   rd;
        logic [31:0]             value;
    } cdb_t;

endpackage

`default_nettype wire

/* rtl/mem_unit_top.sv */
`default_nettype none

module mem_unit_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic                            enq_valid,
    input  lsu_pkg::dispatch_t              enq,
    input  logic                            agu_valid,
    input  lsu_pkg::agu_req_t               agu_req,
    input  logic [lsu_pkg::ROB_IDX_W-1:0]   commit_rob,
    input  logic                            dc_resp_valid,
    input  logic [31:0]                     dc_rdata,
    output logic                            full,
    output logic [lsu_pkg::LSQ_IDX_W-1:0]   next_idx,
    output lsu_pkg::dcache_req_t            dc_req,
    output lsu_pkg::cdb_t                   cdb
);

    logic                  addr_valid;
    lsu_pkg::agu_result_t  addr_res;
    lsu_pkg::retire_t      ret;

    agu u_agu (
        .clk        (clk),
        .rst        (rst),
        .agu_valid  (agu_valid),
        .agu_req    (agu_req),
        .flush      (flush),
        .addr_valid (addr_valid),
        .addr_res   (addr_res)
    );

    lsq #(
        .QUEUE_DEPTH (lsu_pkg::LSQ_DEPTH)
    ) u_lsq (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .enq_valid     (enq_valid),
        .enq           (enq),
        .addr_valid    (addr_valid),
        .addr_res      (addr_res),
        .commit_rob    (commit_rob),
        .dc_resp_valid (dc_resp_valid),
        .dc_rdata      (dc_rdata),
        .full          (full),
        .next_idx      (next_idx),
        .dc_req        (dc_req),
        .ret           (ret)
    );

    load_writeback u_wb (
        .clk (clk),
        .rst (rst),
        .ret (ret),
        .cdb (cdb)
    );

endmodule

`default_nettype wire

/* verification/tb_mem_unit.sv */
`default_nettype none

module tb_mem_unit;

    localparam int NUM_ROWS = 16;
    localparam int BATCH    = lsu_pkg::LSQ_DEPTH;
    localparam int SEED     = 39877;
    localparam lsu_pkg::mem_op_t LD = lsu_pkg::op_load;
    localparam lsu_pkg::mem_op_t ST = lsu_pkg::op_store;

    typedef struct packed {
        lsu_pkg::mem_op_t                op;
        logic [2:0]                      funct3;
        logic [lsu_pkg::ROB_IDX_W-1:0]   rob_idx;
        logic [lsu_pkg::ARCH_REG_W-1:0]  rd;
        logic [31:0]                     base;
        logic [31:0]                     offset;
        logic [31:0]                     data;
    } row_t;

    logic                            clk;
    logic                            rst;
    logic                            flush;
    logic                            enq_valid;
    lsu_pkg::dispatch_t              enq;
    logic                            agu_valid;
    lsu_pkg::agu_req_t               agu_req;
    logic [lsu_pkg::ROB_IDX_W-1:0]   commit_rob;
    logic                            dc_resp_valid;
    logic [31:0]                     dc_rdata;
    logic                            full;
    logic [lsu_pkg::LSQ_IDX_W-1:0]   next_idx;
    lsu_pkg::dcache_req_t            dc_req;
    lsu_pkg::cdb_t                   cdb;

    row_t        rows     [NUM_ROWS];
    logic [31:0] exp_val  [NUM_ROWS];
    logic [3:0]  exp_mask [NUM_ROWS];
    logic [2:0]  slot     [NUM_ROWS];
    int          lat      [NUM_ROWS];    // cache latency per request
    logic [31:0] dmem     [256];
    logic [7:0]  ref_mem  [1024];
    int          errors;

    mem_unit_top u_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic no_request_check();
        assert (dc_req.rmask == '0 && dc_req.wmask == '0) else begin
            errors++;
            $display("cache request seen before its entry was committed");
        end
    endtask

    function automatic logic [31:0] fill_word(input int waddr);
        return (waddr * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
    endfunction

    // reference load from the byte model
    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] a);
        int p;
        p = a[9:0];
        case (f3)
            lsu_pkg::F3_B:  return {{24{ref_mem[p][7]}}, ref_mem[p]};
            lsu_pkg::F3_BU: return {24'b0, ref_mem[p]};
            lsu_pkg::F3_H:  return {{16{ref_mem[p+1][7]}}, ref_mem[p+1], ref_mem[p]};
            lsu_pkg::F3_HU: return {16'b0, ref_mem[p+1], ref_mem[p]};
            default:        return {ref_mem[p+3], ref_mem[p+2], ref_mem[p+1], ref_mem[p]};
        endcase
    endfunction

    task automatic load_rows();
        rows[0]  = {ST, lsu_pkg::F3_W,  5'd0,  5'd3,  32'h100, 32'h0,         32'h8bad_f00d};
        rows[1]  = {LD, lsu_pkg::F3_W,  5'd1,  5'd5,  32'h0f8, 32'h8,         32'h0};
        rows[2]  = {ST, lsu_pkg::F3_B,  5'd2,  5'd4,  32'h100, 32'h1,         32'h0000_007f};
        rows[3]  = {ST, lsu_pkg::F3_H,  5'd3,  5'd1,  32'h104, 32'hffff_fffe, 32'h0000_a5c3};
        rows[4]  = {LD, lsu_pkg::F3_B,  5'd4,  5'd6,  32'h100, 32'h0,         32'h0};
        rows[5]  = {LD, lsu_pkg::F3_BU, 5'd5,  5'd7,  32'h100, 32'h1,         32'h0};
        rows[6]  = {LD, lsu_pkg::F3_H,  5'd6,  5'd8,  32'h100, 32'h2,         32'h0};
        rows[7]  = {LD, lsu_pkg::F3_HU, 5'd7,  5'd9,  32'h100, 32'h0,         32'h0};
        rows[8]  = {ST, lsu_pkg::F3_B,  5'd8,  5'd2,  32'h100, 32'h3,         32'hffff_ff80};
        rows[9]  = {LD, lsu_pkg::F3_B,  5'd9,  5'd10, 32'h100, 32'h3,         32'h0};
        rows[10] = {LD, lsu_pkg::F3_BU, 5'd10, 5'd11, 32'h100, 32'h3,         32'h0};
        rows[11] = {LD, lsu_pkg::F3_B,  5'd11, 5'd12, 32'h100, 32'h2,         32'h0};
        rows[12] = {LD, lsu_pkg::F3_H,  5'd12, 5'd13, 32'h108, 32'hffff_fff8, 32'h0};
        rows[13] = {LD, lsu_pkg::F3_HU, 5'd13, 5'd14, 32'h100, 32'h2,         32'h0};
        rows[14] = {ST, lsu_pkg::F3_W,  5'd14, 5'd16, 32'h200, 32'h4,         32'h1234_5678};
        rows[15] = {LD, lsu_pkg::F3_H,  5'd15, 5'd15, 32'h200, 32'h6,         32'h0};
    endtask

    // program order, so stores land before later loads read
    task automatic expect_rows();
        logic [31:0] a;
        int          n;
        for (int i = 0; i < NUM_ROWS; i++) begin
            a = rows[i].base + rows[i].offset;
            n = 1 << rows[i].funct3[1:0];    // access size in bytes
            exp_mask[i] = '0;
            for (int k = 0; k < n; k++) begin
                exp_mask[i][a[1:0] + k] = 1'b1;
            end
            if (rows[i].op == ST) begin
                for (int k = 0; k < n; k++) begin
                    ref_mem[a[9:0] + k] = rows[i].data[8*k +: 8];
                end
                exp_val[i] = '0;
            end else begin
                exp_val[i] = load_value(rows[i].funct3, a);
            end
        end
    endtask

    task automatic dispatch_rows(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            check_eq("next_idx", next_idx, i);    // queue is empty at the start
            slot[first+i] = next_idx;
            enq_valid = 1'b1;
            enq = {rows[first+i].op, rows[first+i].funct3, rows[first+i].rob_idx,
                   1'b1, rows[first+i].rob_idx, rows[first+i].rd};
            next_cycle();
        end
        enq_valid = 1'b0;
        check_eq("next_idx", next_idx, count % BATCH);
        check_eq("full", full, count == BATCH);
    endtask

    task automatic issue_addresses(input int first, input int count);
        int order [BATCH];
        int j;
        int t;
        for (int i = 0; i < count; i++) begin
            order[i] = i;
        end
        for (int i = count - 1; i > 0; i--) begin
            j = $urandom_range(0, i);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < count; i++) begin
            j = first + order[i];
            agu_valid = 1'b1;
            agu_req = {slot[j], rows[j].base, rows[j].offset, rows[j].data};
            no_request_check();
            next_cycle();
        end
        agu_valid = 1'b0;
        repeat (3) begin
            no_request_check();
            next_cycle();
        end
    endtask

    task automatic drain(input int first, input int count);
        row_t r;
        for (int i = 0; i < count; i++) begin
            r = rows[first+i];
            commit_rob = r.rob_idx;
            #1;    // request follows commit_rob combinationally
            check_eq("dc_req.rmask", dc_req.rmask, (r.op == LD) ? exp_mask[first+i] : 4'd0);
            check_eq("dc_req.wmask", dc_req.wmask, (r.op == ST) ? exp_mask[first+i] : 4'd0);
            do begin
                next_cycle();
            end while (!cdb.valid);
            check_eq("cdb.rob_idx", cdb.rob_idx, r.rob_idx);
            check_eq("cdb.pd", cdb.pd, (r.op == LD) ? {1'b1, r.rob_idx} : 6'd0);
            check_eq("cdb.rd", cdb.rd, (r.op == LD) ? r.rd : 5'd0);
            check_eq("cdb.value", cdb.value, exp_val[first+i]);
            if (i == 0) begin
                check_eq("full", full, 0);    // one retire frees a slot
            end
        end
        commit_rob = commit_rob + 1'b1;
    endtask

    task automatic run_batch(input int first);
        commit_rob = rows[first].rob_idx - 1'b1;
        dispatch_rows(first, BATCH);
        issue_addresses(first, BATCH);
        drain(first, BATCH);
    endtask

    task automatic flush_check(input int first, input int count);
        commit_rob = rows[first].rob_idx - 1'b1;    // hold the head back
        dispatch_rows(first, count);
        issue_addresses(first, count);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        check_eq("full", full, 0);
        check_eq("next_idx", next_idx, 0);
        commit_rob = rows[first].rob_idx;
        repeat (6) begin
            assert (!cdb.valid) else begin
                errors++;
                $display("data bus packet appeared for a flushed entry");
            end
            no_request_check();
            next_cycle();
        end
    endtask

    // data cache model
    initial begin
        int n;
        int idx;
        n = 0;
        dc_resp_valid = 1'b0;
        dc_rdata = '0;
        forever begin
            @(posedge clk);
            #1 dc_resp_valid = 1'b0;
            #1;
            if (rst && (dc_req.rmask != '0 || dc_req.wmask != '0)) begin
                repeat (lat[n % NUM_ROWS] - 1) begin
                    @(posedge clk);
                    #2;
                end
                n++;
                idx = dc_req.addr[9:2];
                dc_rdata = dmem[idx];
                for (int k = 0; k < 4; k++) begin
                    if (dc_req.wmask[k]) begin
                        dmem[idx][8*k +: 8] = dc_req.wdata[8*k +: 8];
                    end
                end
                dc_resp_valid = 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] w;
        errors = 0;
        void'($urandom(SEED));
        rst = 1'b0;
        flush = 1'b0;
        enq_valid = 1'b0;
        enq = '0;
        agu_valid = 1'b0;
        agu_req = '0;
        commit_rob = '0;
        load_rows();
        for (int a = 0; a < 256; a++) begin
            w = fill_word(a);
            dmem[a] = w;
            for (int k = 0; k < 4; k++) begin
                ref_mem[4*a + k] = w[8*k +: 8];
            end
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            lat[i] = $urandom_range(1, 3);
        end
        expect_rows();
        repeat (8) @(posedge clk);
        #1 rst = 1'b1;
        run_batch(0);
        flush_check(8, 3);
        flush_check(8, BATCH);
        run_batch(8);
        repeat (3) next_cycle();
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (NUM_ROWS * 40) @(posedge clk);
        $display("timeout: data bus stalled, %0d errors so far", errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
